// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/icachePkg.sv
      - hdl/lineRam.sv
      - hdl/fetchPort.sv
      - hdl/tagLookup.sv
      - hdl/fillMaster.sv
      - hdl/icacheTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/icacheTbMem.sv
      - tests/icacheTb.sv

// ==== hdl/fetchPort.sv ====
// request stage of the instruction cache
// holds one core request, line-aligned, until the lookup takes it
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module fetchPort (
	input wire logic clk,
	input wire logic rst,
	// core request channel
	input wire logic reqValid,
	output logic reqReady,
	input wire icachePkg::reqKindT reqKind,
	input wire logic [`ICACHE_AW-1:0] reqAdr,
	// link towards the tag lookup
	output logic lkValid,
	input wire logic lkReady,
	output icachePkg::reqKindT lkKind,
	output logic [`ICACHE_AW-1:0] lkAdr
);

	// ----------------------------------------
	// handshakes
	// ----------------------------------------

	logic reqFire;
	logic lkFire;
	logic fullNext;

	// a request is taken when the core offers one and the register is empty
	assign reqFire = reqValid & reqReady;
	// the lookup drains the register on its own handshake
	assign lkFire = lkValid & lkReady;

	// the register fills on a core transfer and stays full until drained
	// reqReady is low whenever full, so both never happen on one edge
	assign fullNext = reqFire | (lkValid & ~lkFire);

	// ----------------------------------------
	// occupancy
	// ----------------------------------------

	// lkValid doubles as the full flag of the one-entry register
	// reqReady is kept as its own flop so the core sees a clean registered
	// ready, it is low in reset and rises on the first edge after it
	always_ff @(posedge clk) begin
		if (rst) begin
			lkValid <= 1'b0;
			reqReady <= 1'b0;
		end else begin
			lkValid <= fullNext;
			reqReady <= ~fullNext;
		end
	end

	// ----------------------------------------
	// payload
	// ----------------------------------------

	// kind and address are captured on the core transfer
	// the byte offset is dropped here so the rest of the cache only ever
	// deals with line-aligned addresses
	always_ff @(posedge clk) begin
		if (reqFire) begin
			lkKind <= reqKind;
			lkAdr <= {reqAdr[`ICACHE_AW-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fillMaster.sv ====
// refill engine of the instruction cache
// AXI4-Lite read master that gathers four beats into one line and a fault flag
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module fillMaster (
	input wire logic clk,
	input wire logic rst,
	// refill link from the lookup
	input wire logic fillStart,
	input wire logic [`ICACHE_AW-1:0] fillAdr,
	output logic fillDone,
	output icachePkg::lineT fillLine,
	output logic fillFault,
	// AXI4-Lite read address channel
	output logic arvalid,
	input wire logic arready,
	output logic [`ICACHE_AW-1:0] araddr,
	output logic [2:0] arprot,
	// AXI4-Lite read data channel
	input wire logic rvalid,
	output logic rready,
	input wire logic [`ICACHE_AXI_DW-1:0] rdata,
	input wire logic [1:0] rresp
);

	// each beat takes an address phase and then a data phase
	typedef enum logic [1:0] {stIdle, stAr, stR} stateT;

	stateT state;
	logic [`ICACHE_AW-1:0] baseQ;
	logic [`ICACHE_BEAT_W-1:0] beatQ;
	logic arFire;
	logic rFire;
	logic lastBeat;

	// ----------------------------------------
	// bus signals
	// ----------------------------------------

	assign arvalid = (state == stAr);
	assign rready = (state == stR);
	// unprivileged, secure, data access
	assign arprot = 3'b000;

	// word address of the current beat, built from registers only so it
	// cannot move while arvalid waits for arready
	assign araddr = {baseQ[`ICACHE_AW-1:`ICACHE_OFS_W], beatQ, {`ICACHE_WOFS_W{1'b0}}};

	assign arFire = arvalid & arready;
	assign rFire = rvalid & rready;
	// beat count is a power of two, so the last beat is all ones
	assign lastBeat = &beatQ;

	// ----------------------------------------
	// beat sequencing
	// ----------------------------------------

	// only one beat is outstanding, the next address goes out after the
	// previous data returned, so a line costs at least eight cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			fillDone <= 1'b0;
		end else begin
			fillDone <= 1'b0;
			case (state)
				stIdle: begin
					if (fillStart) begin
						state <= stAr;
					end
				end
				stAr: begin
					if (arFire) begin
						state <= stR;
					end
				end
				stR: begin
					if (rFire) begin
						if (lastBeat) begin
							state <= stIdle;
							fillDone <= 1'b1;
						end else begin
							state <= stAr;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// ----------------------------------------
	// line assembly
	// ----------------------------------------

	// a new fill restarts the beat count and clears the merged fault
	// each returned word goes into its own lane, beat 0 in the low bits
	// any response other than OKAY marks the whole line as faulted
	always_ff @(posedge clk) begin
		if (state == stIdle && fillStart) begin
			baseQ <= fillAdr;
			beatQ <= '0;
			fillFault <= 1'b0;
		end else if (rFire) begin
			fillLine[beatQ*`ICACHE_AXI_DW +: `ICACHE_AXI_DW] <= rdata;
			fillFault <= fillFault | (rresp != 2'b00);
			beatQ <= beatQ + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icachePkg.sv ====
// shared types of the instruction cache
// request kinds plus the entries kept in the tag and line stores
`default_nettype none

`include "icache_consts.svh"

package icachePkg;

	// ----------------------------------------
	// core request kinds
	// ----------------------------------------

	// fetch reads a line, invLine drops one line if it hits,
	// invAll drops every line at once
	typedef enum logic [1:0] {
		fetch,
		invLine,
		invAll
	} reqKindT;

	// ----------------------------------------
	// store entries
	// ----------------------------------------

	// one full cache line, lowest address in the lowest bits
	typedef logic [`ICACHE_LINE_BYTES*8-1:0] lineT;

	// a tag store entry keeps only the address bits above index and offset
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0] tag;
	} tagEntryT;

	// a line store entry keeps the data and whether any beat of its
	// refill came back with an error response
	typedef struct packed {
		lineT line;
		logic fault;
	} lineEntryT;

endpackage

`default_nettype wire

// ==== hdl/icacheTop.sv ====
// top level of the direct-mapped instruction cache
// request stage, lookup and AXI refill master wired together
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icacheTop (
	input wire logic clk,
	input wire logic rst,
	// core request channel
	input wire logic reqValid,
	output logic reqReady,
	input wire icachePkg::reqKindT reqKind,
	input wire logic [`ICACHE_AW-1:0] reqAdr,
	// core response channel
	output logic respValid,
	input wire logic respReady,
	output icachePkg::lineT respLine,
	output logic respFault,
	output logic [`ICACHE_AW-1:0] respAdr,
	// AXI4-Lite read channels towards memory
	output logic arvalid,
	input wire logic arready,
	output logic [`ICACHE_AW-1:0] araddr,
	output logic [2:0] arprot,
	input wire logic rvalid,
	output logic rready,
	input wire logic [`ICACHE_AXI_DW-1:0] rdata,
	input wire logic [1:0] rresp
);
	import icachePkg::*;

	// ----------------------------------------
	// internal links
	// ----------------------------------------

	// request stage to lookup
	logic lkValid;
	logic lkReady;
	reqKindT lkKind;
	logic [`ICACHE_AW-1:0] lkAdr;

	// lookup to refill master and back
	logic fillStart;
	logic [`ICACHE_AW-1:0] fillAdr;
	logic fillDone;
	lineT fillLine;
	logic fillFault;

	fetchPort port (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .reqReady(reqReady), .reqKind(reqKind), .reqAdr(reqAdr),
		.lkValid(lkValid), .lkReady(lkReady), .lkKind(lkKind), .lkAdr(lkAdr)
	);

	tagLookup lookup (
		.clk(clk), .rst(rst),
		.lkValid(lkValid), .lkReady(lkReady), .lkKind(lkKind), .lkAdr(lkAdr),
		.respValid(respValid), .respReady(respReady), .respLine(respLine),
		.respFault(respFault), .respAdr(respAdr),
		.fillStart(fillStart), .fillAdr(fillAdr), .fillDone(fillDone),
		.fillLine(fillLine), .fillFault(fillFault)
	);

	fillMaster fill (
		.clk(clk), .rst(rst),
		.fillStart(fillStart), .fillAdr(fillAdr), .fillDone(fillDone),
		.fillLine(fillLine), .fillFault(fillFault),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

endmodule

`default_nettype wire

// ==== hdl/icache_consts.svh ====
// sizing constants for the direct-mapped instruction cache
// every width in the design follows from these few values
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// ----------------------------------------
// base sizes
// ----------------------------------------

// byte address width seen by the core and on the AXI bus
`define ICACHE_AW 32
// number of lines in the direct-mapped store
`define ICACHE_LINES 64
// bytes held by one line
`define ICACHE_LINE_BYTES 16
// width of one AXI read beat
`define ICACHE_AXI_DW 32
// beats needed to refill one line
`define ICACHE_BEATS 4

// ----------------------------------------
// derived field widths
// ----------------------------------------

// byte offset inside a line, then the index that picks the line
`define ICACHE_OFS_W $clog2(`ICACHE_LINE_BYTES)
`define ICACHE_IDX_W $clog2(`ICACHE_LINES)
// the tag is whatever address bits sit above index and offset
`define ICACHE_TAG_W (`ICACHE_AW - `ICACHE_IDX_W - `ICACHE_OFS_W)
// beat counter width and the byte offset inside one beat
`define ICACHE_BEAT_W $clog2(`ICACHE_BEATS)
`define ICACHE_WOFS_W $clog2(`ICACHE_AXI_DW / 8)

`endif

// ==== hdl/lineRam.sv ====
// small distributed RAM, one entry per cache line
// synchronous write and combinational read of any payload type
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module lineRam #(
	parameter type payloadT = logic
) (
	input wire logic clk,
	input wire logic we,
	input wire logic [`ICACHE_IDX_W-1:0] addr,
	input wire payloadT wdata,
	output payloadT rdata
);

	// ----------------------------------------
	// storage
	// ----------------------------------------

	// one word per line, whether a word is meaningful is tracked by the
	// valid bits in the lookup, so the array itself has no clear
	payloadT mem [0:`ICACHE_LINES-1];

	// a write lands on the clock edge at the given line
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------

	// read is asynchronous so the lookup sees the entry in the same cycle
	// the address is presented, which maps onto LUT based RAM
	// a word written on an edge is visible right after that edge
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== hdl/tagLookup.sv ====
// lookup stage of the instruction cache
// owns tag store, line store and valid bits, decides hit or miss and answers the core
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module tagLookup (
	input wire logic clk,
	input wire logic rst,
	// link from the request stage
	input wire logic lkValid,
	output logic lkReady,
	input wire icachePkg::reqKindT lkKind,
	input wire logic [`ICACHE_AW-1:0] lkAdr,
	// response channel to the core
	output logic respValid,
	input wire logic respReady,
	output icachePkg::lineT respLine,
	output logic respFault,
	output logic [`ICACHE_AW-1:0] respAdr,
	// refill link to the AXI read master
	output logic fillStart,
	output logic [`ICACHE_AW-1:0] fillAdr,
	input wire logic fillDone,
	input wire icachePkg::lineT fillLine,
	input wire logic fillFault
);
	import icachePkg::*;

	// look is the cycle after acceptance where the stored tag is compared
	typedef enum logic [1:0] {stIdle, stLook, stFill, stResp} stateT;

	stateT state;
	logic [`ICACHE_AW-1:0] adrQ;
	logic [`ICACHE_LINES-1:0] validQ;
	logic [`ICACHE_AW-1:0] curAdr;
	logic [`ICACHE_IDX_W-1:0] idx;
	logic [`ICACHE_TAG_W-1:0] tag;
	tagEntryT tagRd;
	tagEntryT tagWr;
	lineEntryT lineRd;
	lineEntryT lineWr;
	logic hit;
	logic lkFire;
	logic fillWe;

	// ----------------------------------------
	// address split and hit check
	// ----------------------------------------

	// while idle the stores are addressed straight from the link so an
	// invalidate can check its tag on the handshake edge itself
	assign curAdr = (state == stIdle) ? lkAdr : adrQ;
	assign idx = curAdr[`ICACHE_IDX_W+`ICACHE_OFS_W-1:`ICACHE_OFS_W];
	assign tag = curAdr[`ICACHE_AW-1:`ICACHE_IDX_W+`ICACHE_OFS_W];

	// a stale tag never hits because its valid bit gates the compare
	assign hit = validQ[idx] && (tagRd.tag == tag);

	assign lkReady = (state == stIdle);
	assign lkFire = lkValid & lkReady;
	// a refilled line and its tag are written on the fillDone edge
	assign fillWe = (state == stFill) && fillDone;

	assign tagWr = '{tag: tag};
	assign lineWr = '{line: fillLine, fault: fillFault};

	lineRam #(.payloadT(tagEntryT)) tagRam (
		.clk(clk),
		.we(fillWe),
		.addr(idx),
		.wdata(tagWr),
		.rdata(tagRd)
	);

	lineRam #(.payloadT(lineEntryT)) dataRam (
		.clk(clk),
		.we(fillWe),
		.addr(idx),
		.wdata(lineWr),
		.rdata(lineRd)
	);

	// ----------------------------------------
	// sequencing
	// ----------------------------------------

	// fetches walk idle, look, then either respond or fill and respond
	// invalidates never leave idle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			fillStart <= 1'b0;
		end else begin
			fillStart <= 1'b0;
			case (state)
				stIdle: begin
					if (lkFire && lkKind == fetch) begin
						state <= stLook;
					end
				end
				stLook: begin
					if (hit) begin
						state <= stResp;
					end else begin
						// one cycle pulse, the fill master latches fillAdr on it
						state <= stFill;
						fillStart <= 1'b1;
					end
				end
				stFill: begin
					if (fillDone) begin
						state <= stResp;
					end
				end
				stResp: begin
					if (respReady) begin
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// the accepted address stays put for the whole lookup and refill
	always_ff @(posedge clk) begin
		if (lkFire) begin
			adrQ <= lkAdr;
		end
	end

	// invAll wins over everything, invLine only drops a line whose tag matches
	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= '0;
		end else if (lkFire && lkKind == invAll) begin
			validQ <= '0;
		end else if (lkFire && lkKind == invLine && hit) begin
			validQ[idx] <= 1'b0;
		end else if (fillWe) begin
			validQ[idx] <= 1'b1;
		end
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------

	// the line store is read at adrQ's index, which holds still while responding
	assign respValid = (state == stResp);
	assign respLine = lineRd.line;
	assign respFault = lineRd.fault;
	assign respAdr = adrQ;
	assign fillAdr = adrQ;

endmodule

`default_nettype wire

// ==== tests/icacheTb.sv ====
// testbench for the direct-mapped instruction cache
// random fetches and invalidates checked against a tag model and the memory function
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icacheTb;
	import icachePkg::*;

	localparam logic [31:0] dataKey = 32'hA5C3_0F69;
	// reads in this 256-byte window come back with SLVERR
	localparam logic [31:0] errBase = 32'h0000_0300;
	localparam int numRandom = 400;
	localparam int totalReqs = numRandom + 40;
	// four beats of up to 4 AR and 4 R cycles each, plus lookup and response stalls
	localparam int worstCycles = 64;

	logic clk;
	logic rst;
	logic reqValid;
	logic reqReady;
	reqKindT reqKind;
	logic [31:0] reqAdr;
	logic respValid;
	logic respReady;
	lineT respLine;
	logic respFault;
	logic [31:0] respAdr;
	logic arvalid;
	logic arready;
	logic [31:0] araddr;
	logic [2:0] arprot;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;

	integer seed;
	integer stallSeed;
	int checks;
	int errors;
	int stallAccepts;
	// reference model of the valid bits and tags kept in request order
	logic mValid [0:`ICACHE_LINES-1];
	logic [`ICACHE_TAG_W-1:0] mTag [0:`ICACHE_LINES-1];
	// outstanding fetches and whether each one must refill
	logic [31:0] expAdrQ [$];
	bit expMissQ [$];
	// AR handshakes seen since the last response
	logic [31:0] arQ [$];

	// ----------------------------------------
	// clock, DUT and memory
	// ----------------------------------------

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	icacheTop uut (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .reqReady(reqReady), .reqKind(reqKind), .reqAdr(reqAdr),
		.respValid(respValid), .respReady(respReady), .respLine(respLine),
		.respFault(respFault), .respAdr(respAdr),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	icacheTbMem #(.dataKey(dataKey), .errBase(errBase)) mem (
		.clk(clk), .rst(rst),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	// ----------------------------------------
	// model helpers and checks
	// ----------------------------------------

	task automatic checkEq(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// the line as memory holds it with word 0 in the low bits
	function automatic lineT expLine(input logic [31:0] adr);
		lineT l;
		int i;
		for (i = 0; i < `ICACHE_BEATS; i++) begin
			l[i*32 +: 32] = (adr + i * 4) ^ dataKey;
		end
		return l;
	endfunction

	function automatic logic inErr(input logic [31:0] adr);
		return adr[31:8] == errBase[31:8];
	endfunction

	// offers one request, waits for its transfer and updates the model
	task automatic sendReq(input reqKindT kind, input logic [31:0] adr);
		logic [31:0] lineAdr;
		logic [`ICACHE_IDX_W-1:0] idx;
		logic [`ICACHE_TAG_W-1:0] tg;
		int i;
		lineAdr = adr & ~32'(`ICACHE_LINE_BYTES - 1);
		idx = (adr / `ICACHE_LINE_BYTES) % `ICACHE_LINES;
		tg = adr / (`ICACHE_LINE_BYTES * `ICACHE_LINES);
		@(negedge clk);
		reqValid = 1'b1;
		reqKind = kind;
		reqAdr = adr;
		@(posedge clk);
		while (!reqReady) @(posedge clk);
		case (kind)
			fetch: begin
				expAdrQ.push_back(lineAdr);
				expMissQ.push_back(!(mValid[idx] && mTag[idx] == tg));
				mValid[idx] = 1'b1;
				mTag[idx] = tg;
			end
			invLine: begin
				if (mValid[idx] && mTag[idx] == tg) begin
					mValid[idx] = 1'b0;
				end
			end
			default: begin
				for (i = 0; i < `ICACHE_LINES; i++) begin
					mValid[i] = 1'b0;
				end
			end
		endcase
	endtask

	// stops offering requests and lets every pending response come back
	task automatic drain();
		@(negedge clk);
		reqValid = 1'b0;
		while (expAdrQ.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
	endtask

	task automatic endTest(input string name, input int errBefore);
		$display("test %s finished with %0d errors", name, errors - errBefore);
	endtask

	// compares one taken response with the oldest expected fetch
	task automatic checkResp();
		logic [31:0] adr;
		bit miss;
		int i;
		if (expAdrQ.size() == 0) begin
			errors++;
			$display("a response arrived at %0t with no fetch outstanding", $time);
		end else begin
			adr = expAdrQ.pop_front();
			miss = expMissQ.pop_front();
			checkEq("respAdr", respAdr, adr);
			checkEq("respLine", respLine, expLine(adr));
			checkEq("respFault", respFault, inErr(adr));
			// a hit reads nothing and a miss reads four consecutive words
			checkEq("AR count", arQ.size(), miss ? 4 : 0);
			for (i = 0; i < arQ.size(); i++) begin
				checkEq("araddr", arQ[i], adr + i * 4);
			end
			arQ.delete();
		end
	endtask

	// ----------------------------------------
	// monitors
	// ----------------------------------------

	// while a response is stalled the request stage can take at most one
	// more request and reqReady has to stay low after that
	always @(posedge clk) begin
		if (arvalid && arready) begin
			arQ.push_back(araddr);
			// every refill read is an unprivileged data access
			checkEq("arprot", arprot, 0);
		end
		if (respValid && !respReady && reqValid) begin
			if (stallAccepts != 0) begin
				checkEq("reqReady", reqReady, 0);
			end
			if (reqReady) begin
				stallAccepts++;
			end
		end
		if (respValid && respReady) begin
			checkResp();
			stallAccepts = 0;
		end
	end

	// the core takes responses on two cycles out of three
	initial begin
		stallSeed = 13173;
		respReady = 1'b0;
		forever begin
			@(negedge clk);
			respReady = ($unsigned($random(stallSeed)) % 3) != 0;
		end
	end

	initial begin
		#(totalReqs * worstCycles * 4 + 16 * 4 + 200);
		$display("timeout: the cache stopped answering before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	// ----------------------------------------
	// tests
	// ----------------------------------------

	initial begin
		int errBefore;
		int i;
		int r;
		logic [31:0] a;
		seed = 13173;
		checks = 0;
		errors = 0;
		stallAccepts = 0;
		rst = 1'b1;
		reqValid = 1'b0;
		reqKind = fetch;
		reqAdr = '0;
		for (i = 0; i < `ICACHE_LINES; i++) begin
			mValid[i] = 1'b0;
		end
		repeat (16) @(posedge clk);
		checkEq("reqReady", reqReady, 0);
		checkEq("respValid", respValid, 0);
		checkEq("arvalid", arvalid, 0);
		checkEq("rready", rready, 0);
		@(negedge clk);
		rst = 1'b0;

		// every first fetch after reset misses
		errBefore = errors;
		for (i = 0; i < 8; i++) begin
			sendReq(fetch, 32'h0000_0100 + i * 32'h44);
		end
		drain();
		endTest("reset misses", errBefore);

		// the fault flag stays with the line on later hits
		errBefore = errors;
		sendReq(fetch, 32'h0000_0308);
		sendReq(fetch, 32'h0000_030C);
		sendReq(fetch, 32'h0000_03F4);
		sendReq(fetch, 32'h0000_0208);
		sendReq(fetch, 32'h0000_0304);
		drain();
		endTest("error region", errBefore);

		// a foreign tag in the same index must not drop the resident line
		errBefore = errors;
		sendReq(fetch, 32'h0000_0540);
		sendReq(invLine, 32'h0000_0944);
		sendReq(fetch, 32'h0000_0548);
		sendReq(invLine, 32'h0000_054C);
		sendReq(fetch, 32'h0000_0540);
		drain();
		endTest("invalidate line", errBefore);

		errBefore = errors;
		for (i = 0; i < 3; i++) begin
			sendReq(fetch, i * 32'h10);
		end
		sendReq(invAll, '0);
		for (i = 0; i < 3; i++) begin
			sendReq(fetch, i * 32'h10 + 4);
		end
		drain();
		endTest("invalidate all", errBefore);

		// mixed traffic over four tags so hits, conflicts and faults all occur
		errBefore = errors;
		for (i = 0; i < numRandom; i++) begin
			r = $unsigned($random(seed)) % 20;
			a = $random(seed) & 32'h0000_0FFF;
			if (r < 16) begin
				sendReq(fetch, a);
			end else if (r < 19) begin
				sendReq(invLine, a);
			end else begin
				sendReq(invAll, a);
			end
		end
		drain();
		endTest("random traffic", errBefore);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/icacheTbMem.sv ====
// AXI4-Lite read slave memory model for the cache testbench
// answers each read with a word derived from its address after random waits
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icacheTbMem #(
	parameter logic [`ICACHE_AW-1:0] dataKey = '0,
	parameter logic [`ICACHE_AW-1:0] errBase = '0
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic arvalid,
	output logic arready,
	input wire logic [`ICACHE_AW-1:0] araddr,
	output logic rvalid,
	input wire logic rready,
	output logic [`ICACHE_AXI_DW-1:0] rdata,
	output logic [1:0] rresp
);

	integer seed;
	logic [`ICACHE_AW-1:0] adr;

	// ----------------------------------------
	// one read at a time
	// ----------------------------------------

	// every output changes on the falling edge so the master samples it
	// cleanly on the next rising edge
	// the word is the address XOR a key, and one 256-byte window answers SLVERR
	initial begin
		seed = 13173;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		forever begin
			@(negedge clk);
			if (!rst && arvalid) begin
				// address phase after 0 to 3 wait cycles, araddr is held by the master
				repeat ($unsigned($random(seed)) % 4) @(negedge clk);
				adr = araddr;
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				// data phase after another 0 to 3 wait cycles
				repeat ($unsigned($random(seed)) % 4) @(negedge clk);
				while (!rready) @(negedge clk);
				rdata = adr ^ dataKey;
				rresp = (adr[`ICACHE_AW-1:8] == errBase[`ICACHE_AW-1:8]) ? 2'b10 : 2'b00;
				rvalid = 1'b1;
				@(negedge clk);
				rvalid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/icachePkg.sv
hdl/lineRam.sv
hdl/fetchPort.sv
hdl/tagLookup.sv
hdl/fillMaster.sv
hdl/icacheTop.sv
tests/icacheTbMem.sv
tests/icacheTb.sv
